//--- test/pkt_comm_trace.txt
# I <count> <hex bytes>  one input packet with tlast on its last byte
# O <count> <hex bytes>  one expected result with tlast on its last byte; S <hex> final status
# Type 1 with one payload byte
I 10 02 01 01 00 01 00 00 00 5a 5a
O 10 01 02 01 00 01 00 00 00 5a 00
# Type 2 with four payload bytes
I 13 02 02 34 12 04 00 00 00 10 20 30 40 a0
O 10 02 02 34 12 04 00 00 00 a0 00
# Version 3 is rejected
I 10 03 01 05 00 01 00 00 00 11 11
# Type 3 whose sum carries into the high byte
I 15 02 03 ef be 06 00 00 00 ff ff ff ff ff ff fa
O 10 03 02 ef be 06 00 00 00 fa 05
# Types 0 and 5 are rejected
I 10 02 00 06 00 01 00 00 00 22 22
I 10 02 05 07 00 01 00 00 00 33 33
# Type 4 with sixteen payload bytes
I 25 02 04 5a a5 10 00 00 00 80 81 82 83 84 85 86 87 88 89 8a 8b 8c 8d 8e 8f 78
O 10 04 02 5a a5 10 00 00 00 78 08
# Wrong checksum
I 11 02 01 08 00 02 00 00 00 01 02 04
# Early tlast against length 5
I 11 02 02 09 00 05 00 00 00 01 02 03
# Late tlast against length 2
I 12 02 03 0a 00 02 00 00 00 01 02 03 07
# Length above the maximum
I 10 02 01 0b 00 01 00 10 00 44 44
# Zero length
I 9 02 01 0c 00 00 00 00 00 55
# tlast inside the header
I 4 02 01 0d 00
# Good packet after the errors
I 12 02 02 80 7f 03 00 00 00 c8 64 32 5e
O 10 02 02 80 7f 03 00 00 00 5e 01
# Version, type, length and checksum bits all set
S f

//--- pkt_comm_axis8.f
+incdir+hdl
hdl/pkt_comm_pkg.sv
hdl/axis_in_fifo.sv
hdl/inpkt_header.sv
hdl/payload_summary.sv
hdl/outpkt_builder.sv
hdl/word_to_axis8.sv
hdl/comm_status.sv
hdl/pkt_comm_axis8.sv
test/tb_pkt_comm_axis8.sv

//--- test/tb_pkt_comm_axis8.sv
/*
 * Trace-driven testbench for the packet front end. Reads test/pkt_comm_trace.txt
 * relative to the project root. Random input gaps and output stalls, fixed seed.
 */
module tb_pkt_comm_axis8;
  timeunit 1ns;
  timeprecision 100ps;
  import pkt_comm_pkg::*;

  logic      CLK;
  logic      RSTN;
  byte_t     s_axis_tdata;
  logic      s_axis_tvalid;
  logic      s_axis_tready;
  logic      s_axis_tlast;
  byte_t     m_axis_tdata;
  logic      m_axis_tvalid;
  logic      m_axis_tready;
  logic      m_axis_tlast;
  err_bits_t pkt_comm_status;
  logic      error;
  logic      idle;

  // Entries are {tlast, byte}
  logic [8:0] in_q[$];
  logic [8:0] exp_q[$];
  err_bits_t  exp_status;
  int         n_out;
  bit         trace_loaded;

  pkt_comm_axis8 uut (
    .CLK(CLK), .RSTN(RSTN),
    .s_axis_tdata(s_axis_tdata), .s_axis_tvalid(s_axis_tvalid),
    .s_axis_tready(s_axis_tready), .s_axis_tlast(s_axis_tlast),
    .m_axis_tdata(m_axis_tdata), .m_axis_tvalid(m_axis_tvalid),
    .m_axis_tready(m_axis_tready), .m_axis_tlast(m_axis_tlast),
    .pkt_comm_status(pkt_comm_status), .error(error), .idle(idle)
  );

  initial CLK = 1'b0;
  always #5 CLK = ~CLK;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "check mismatch");
    end
  endtask

  task automatic load_trace();
    int fd;
    int c;
    int n;
    int b;
    int i;
    fd = $fopen("test/pkt_comm_trace.txt", "r");
    if (fd == 0) abort_run("Could not open the trace file test/pkt_comm_trace.txt");
    c = $fgetc(fd);
    while (c != -1) begin
      if (c == "#") begin
        while (c != -1 && c != "\n") c = $fgetc(fd);
      end else if (c == "I" || c == "O") begin
        if ($fscanf(fd, "%d", n) != 1) abort_run("Trace file has a line without a count");
        for (i = 0; i < n; i++) begin
          if ($fscanf(fd, "%h", b) != 1) abort_run("Trace file line is short of bytes");
          if (c == "I") in_q.push_back({i == n - 1, b[7:0]});
          else exp_q.push_back({i == n - 1, b[7:0]});
        end
      end else if (c == "S") begin
        if ($fscanf(fd, "%h", b) != 1) abort_run("Trace file status line is unreadable");
        exp_status = b[3:0];
      end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
        abort_run("Trace file holds an unknown line type");
      end
      c = $fgetc(fd);
    end
    $fclose(fd);
  endtask

  initial begin : drive_input
    int  idx;
    bit  accepted;
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
    s_axis_tdata  = '0;
    idx = 0;
    @(posedge RSTN);
    while (idx < in_q.size()) begin
      // Ready is registered state, so the negedge value holds at the next edge
      @(negedge CLK);
      accepted = s_axis_tvalid && s_axis_tready;
      @(posedge CLK);
      if (accepted) idx++;
      if (!s_axis_tvalid || accepted) begin
        if (idx < in_q.size() && $urandom_range(3) != 0) begin
          s_axis_tvalid <= 1'b1;
          {s_axis_tlast, s_axis_tdata} <= in_q[idx];
        end else begin
          s_axis_tvalid <= 1'b0;
        end
      end
    end
  end

  initial begin : stall_output
    m_axis_tready = 1'b0;
    @(posedge RSTN);
    forever begin
      @(posedge CLK);
      m_axis_tready <= ($urandom_range(3) != 0);
    end
  end

  initial begin : watch_output
    n_out = 0;
    @(posedge RSTN);
    forever begin
      @(negedge CLK);
      if (m_axis_tvalid && m_axis_tready) begin
        if (n_out >= exp_q.size()) abort_run("DUT sent an output byte beyond the expected ones");
        check_value(m_axis_tdata, exp_q[n_out][7:0], $sformatf("output byte %0d", n_out));
        check_value(m_axis_tlast, exp_q[n_out][8], $sformatf("tlast of byte %0d", n_out));
        n_out++;
      end
    end
  end

  initial begin : watchdog
    int limit;
    wait (trace_loaded);
    limit = 20 * (in_q.size() + exp_q.size()) + 2000;
    repeat (limit) @(posedge CLK);
    abort_run($sformatf("Simulation timed out after %0d cycles", limit));
  end

  initial begin : main
    RSTN = 1'b0;
    exp_status = '0;
    trace_loaded = 1'b0;
    void'($urandom(32'hfd2d_59cf));
    load_trace();
    trace_loaded = 1'b1;
    repeat (10) @(posedge CLK);
    check_value(m_axis_tvalid, 1'b0, "m_axis_tvalid in reset");
    check_value(pkt_comm_status, 4'h0, "status in reset");
    check_value(error, 1'b0, "error in reset");
    check_value(idle, 1'b0, "idle in reset");
    RSTN <= 1'b1;
    @(negedge CLK);
    check_value(s_axis_tready, 1'b1, "s_axis_tready after reset");
    check_value(m_axis_tvalid, 1'b0, "m_axis_tvalid after reset");
    check_value(pkt_comm_status, 4'h0, "status after reset");
    wait (n_out == exp_q.size());
    while (!idle) @(negedge CLK);
    check_value(pkt_comm_status, exp_status, "final status");
    check_value(error, |exp_status, "final error");
    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- hdl/pkt_comm_axis8.sv
/*
 * Packet front end top. 8-bit stream in and out, both with tlast.
 * Results leave in input order; bad packets produce no output.
 */
module pkt_comm_axis8 (
  input  logic                    CLK,
  input  logic                    RSTN,
  input  pkt_comm_pkg::byte_t     s_axis_tdata,
  input  logic                    s_axis_tvalid,
  output logic                    s_axis_tready,
  input  logic                    s_axis_tlast,
  output pkt_comm_pkg::byte_t     m_axis_tdata,
  output logic                    m_axis_tvalid,
  input  logic                    m_axis_tready,
  output logic                    m_axis_tlast,
  output pkt_comm_pkg::err_bits_t pkt_comm_status,
  output logic                    error,
  output logic                    idle
);
  import pkt_comm_pkg::*;

  byte_t     fifo_data;
  logic      fifo_last, fifo_valid, fifo_ready;
  pl_byte_s  pl;
  logic      pl_valid, pl_ready;
  pkt_type_t hdr_type;
  pkt_id_t   hdr_id;
  pkt_len_t  hdr_len;
  summary_s  summary;
  logic      sum_valid, sum_ready;
  word_t     word;
  logic      word_last, word_valid, word_ready;
  logic      err_version, err_type, err_len, err_cks;
  logic      hdr_busy, sum_busy, bld_busy, ser_busy;

  axis_in_fifo u_in_fifo (
    .CLK(CLK), .RSTN(RSTN),
    .s_axis_tdata(s_axis_tdata), .s_axis_tvalid(s_axis_tvalid),
    .s_axis_tready(s_axis_tready), .s_axis_tlast(s_axis_tlast),
    .out_data(fifo_data), .out_last(fifo_last),
    .out_valid(fifo_valid), .out_ready(fifo_ready)
  );

  inpkt_header u_header (
    .CLK(CLK), .RSTN(RSTN),
    .in_data(fifo_data), .in_last(fifo_last), .in_valid(fifo_valid), .in_ready(fifo_ready),
    .pl_out(pl), .pl_valid(pl_valid), .pl_ready(pl_ready),
    .hdr_type(hdr_type), .hdr_id(hdr_id), .hdr_len(hdr_len),
    .err_version(err_version), .err_type(err_type), .err_len(err_len), .busy(hdr_busy)
  );

  payload_summary u_summary (
    .CLK(CLK), .RSTN(RSTN),
    .pl_in(pl), .pl_valid(pl_valid), .pl_ready(pl_ready),
    .hdr_type(hdr_type), .hdr_id(hdr_id), .hdr_len(hdr_len),
    .sum_out(summary), .sum_valid(sum_valid), .sum_ready(sum_ready),
    .err_cks(err_cks), .busy(sum_busy)
  );

  outpkt_builder u_builder (
    .CLK(CLK), .RSTN(RSTN),
    .sum_in(summary), .sum_valid(sum_valid), .sum_ready(sum_ready),
    .word_out(word), .word_last(word_last), .word_valid(word_valid), .word_ready(word_ready),
    .busy(bld_busy)
  );

  word_to_axis8 u_serializer (
    .CLK(CLK), .RSTN(RSTN),
    .word_in(word), .word_last(word_last), .word_valid(word_valid), .word_ready(word_ready),
    .m_axis_tdata(m_axis_tdata), .m_axis_tvalid(m_axis_tvalid),
    .m_axis_tready(m_axis_tready), .m_axis_tlast(m_axis_tlast),
    .busy(ser_busy)
  );

  // Buffered bytes count as input-stage activity
  comm_status u_status (
    .CLK(CLK), .RSTN(RSTN),
    .err_version(err_version), .err_type(err_type), .err_len(err_len), .err_cks(err_cks),
    .s_axis_tvalid(s_axis_tvalid),
    .stage_busy({ser_busy, bld_busy, sum_busy, hdr_busy | fifo_valid}),
    .pkt_comm_status(pkt_comm_status), .error(error), .idle(idle)
  );

endmodule

//--- hdl/comm_status.sv
/*
 * Sticky error bits and idle detection. Bits clear only on reset.
 * idle rises IDLE_CYCLES cycles after the last input valid or busy stage.
 */
`include "pkt_comm_consts.svh"

module comm_status #(
  parameter int IDLE_CYCLES = `IDLE_DELAY
) (
  input  logic                    CLK,
  input  logic                    RSTN,
  input  logic                    err_version,
  input  logic                    err_type,
  input  logic                    err_len,
  input  logic                    err_cks,
  input  logic                    s_axis_tvalid,
  input  logic [3:0]              stage_busy,
  output pkt_comm_pkg::err_bits_t pkt_comm_status,
  output logic                    error,
  output logic                    idle
);
  import pkt_comm_pkg::*;

  localparam int CW = $clog2(IDLE_CYCLES + 1);

  logic [CW-1:0] quiet_cnt;

  assign error = |pkt_comm_status;
  assign idle  = (quiet_cnt == CW'(IDLE_CYCLES));

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      pkt_comm_status <= '0;
      quiet_cnt       <= '0;
    end else begin
      pkt_comm_status <= pkt_comm_status | {err_version, err_type, err_len, err_cks};
      if (s_axis_tvalid || |stage_busy) quiet_cnt <= '0;
      else if (!idle) quiet_cnt <= quiet_cnt + 1'b1;
    end
  end

endmodule

//--- hdl/word_to_axis8.sv
/*
 * 16-bit word to 8-bit stream, low byte first.
 * A new word is taken in the same cycle as the final high-byte transfer.
 */
module word_to_axis8 (
  input  logic                CLK,
  input  logic                RSTN,
  input  pkt_comm_pkg::word_t word_in,
  input  logic                word_last,
  input  logic                word_valid,
  output logic                word_ready,
  output pkt_comm_pkg::byte_t m_axis_tdata,
  output logic                m_axis_tvalid,
  input  logic                m_axis_tready,
  output logic                m_axis_tlast,
  output logic                busy
);
  import pkt_comm_pkg::*;

  typedef enum logic {LOW_BYTE, HIGH_BYTE} ser_state_e;

  ser_state_e state;
  word_t      word_r;
  logic       last_r;
  logic       vld;

  assign word_ready    = ~vld || ((state == HIGH_BYTE) && m_axis_tready);
  assign m_axis_tvalid = vld;
  assign m_axis_tdata  = (state == LOW_BYTE) ? word_r[7:0] : word_r[15:8];
  assign m_axis_tlast  = vld && (state == HIGH_BYTE) && last_r;
  assign busy          = vld;

  always_ff @(posedge CLK) begin
    if (word_valid && word_ready) begin
      word_r <= word_in;
      last_r <= word_last;
    end
  end

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      state <= LOW_BYTE;
      vld   <= 1'b0;
    end else if (word_valid && word_ready) begin
      state <= LOW_BYTE;
      vld   <= 1'b1;
    end else if (vld && m_axis_tready) begin
      if (state == LOW_BYTE) begin
        state <= HIGH_BYTE;
      end else begin
        state <= LOW_BYTE;
        vld   <= 1'b0;
      end
    end
  end

  a_hold_on_stall: assert property (@(posedge CLK) disable iff (!RSTN)
    (m_axis_tvalid && !m_axis_tready) |=> (m_axis_tvalid && $stable(m_axis_tdata)))
    else $error("output byte changed during stall");

endmodule

//--- hdl/outpkt_builder.sv
/*
 * Result word builder, five 16-bit words per summary record.
 * The next record is taken one cycle after word 4 transfers.
 */
`include "pkt_comm_consts.svh"

module outpkt_builder (
  input  logic                   CLK,
  input  logic                   RSTN,
  input  pkt_comm_pkg::summary_s sum_in,
  input  logic                   sum_valid,
  output logic                   sum_ready,
  output pkt_comm_pkg::word_t    word_out,
  output logic                   word_last,
  output logic                   word_valid,
  input  logic                   word_ready,
  output logic                   busy
);
  import pkt_comm_pkg::*;

  summary_s   rec;
  logic       have;
  logic [2:0] word_idx;

  assign sum_ready  = ~have;
  assign word_valid = have;
  assign word_last  = (word_idx == 3'd4);
  assign busy       = have;

  always_comb begin
    case (word_idx)
      3'd0:    word_out = {8'(`PKT_COMM_VERSION), rec.pkt_type};
      3'd1:    word_out = rec.pkt_id;
      3'd2:    word_out = rec.pkt_len[15:0];
      3'd3:    word_out = {8'h00, rec.pkt_len[23:16]};
      default: word_out = rec.sum;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (sum_valid && sum_ready) rec <= sum_in;
  end

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      have     <= 1'b0;
      word_idx <= '0;
    end else if (sum_valid && sum_ready) begin
      have     <= 1'b1;
      word_idx <= '0;
    end else if (word_valid && word_ready) begin
      if (word_last) begin
        have     <= 1'b0;
        word_idx <= '0;
      end else begin
        word_idx <= word_idx + 3'd1;
      end
    end
  end

  a_word_idx_range: assert property (@(posedge CLK) disable iff (!RSTN)
    word_idx <= 3'd4)
    else $error("word index past 4");

endmodule

//--- hdl/payload_summary.sv
/*
 * Payload sum and checksum check. Holds one summary record; the parser is stalled
 * while it is held. Rejected and length-error bytes only clear the sum.
 */
module payload_summary (
  input  logic                    CLK,
  input  logic                    RSTN,
  input  pkt_comm_pkg::pl_byte_s  pl_in,
  input  logic                    pl_valid,
  output logic                    pl_ready,
  input  pkt_comm_pkg::pkt_type_t hdr_type,
  input  pkt_comm_pkg::pkt_id_t   hdr_id,
  input  pkt_comm_pkg::pkt_len_t  hdr_len,
  output pkt_comm_pkg::summary_s  sum_out,
  output logic                    sum_valid,
  input  logic                    sum_ready,
  output logic                    err_cks,
  output logic                    busy
);
  import pkt_comm_pkg::*;

  sum_t acc;
  logic pl_xfer;
  logic cks_byte;
  logic load;

  assign pl_ready = ~sum_valid;
  assign pl_xfer  = pl_valid && pl_ready;
  assign cks_byte = pl_xfer && (pl_in.kind == KIND_CHECKSUM) && pl_in.last && !pl_in.len_err;
  assign load     = cks_byte && (acc[7:0] == pl_in.data);
  assign err_cks  = cks_byte && (acc[7:0] != pl_in.data);
  assign busy     = sum_valid;

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      acc       <= '0;
      sum_valid <= 1'b0;
    end else begin
      if (pl_xfer) begin
        if (pl_in.last) acc <= '0;
        else if (pl_in.kind == KIND_PAYLOAD) acc <= acc + sum_t'(pl_in.data);
      end
      if (load) sum_valid <= 1'b1;
      else if (sum_ready) sum_valid <= 1'b0;
    end
  end

  // Header fields are still stable on the checksum byte
  always_ff @(posedge CLK) begin
    if (load) begin
      sum_out <= '{pkt_type: hdr_type, pkt_id: hdr_id, pkt_len: hdr_len, sum: acc};
    end
  end

endmodule

//--- hdl/inpkt_header.sv
/*
 * Header parser and length tagging. Header bytes are never stalled; every byte after
 * the header is forwarded up to tlast. Header fields hold until the next header starts.
 */
`include "pkt_comm_consts.svh"

module inpkt_header (
  input  logic                    CLK,
  input  logic                    RSTN,
  input  pkt_comm_pkg::byte_t     in_data,
  input  logic                    in_last,
  input  logic                    in_valid,
  output logic                    in_ready,
  output pkt_comm_pkg::pl_byte_s  pl_out,
  output logic                    pl_valid,
  input  logic                    pl_ready,
  output pkt_comm_pkg::pkt_type_t hdr_type,
  output pkt_comm_pkg::pkt_id_t   hdr_id,
  output pkt_comm_pkg::pkt_len_t  hdr_len,
  output logic                    err_version,
  output logic                    err_type,
  output logic                    err_len,
  output logic                    busy
);
  import pkt_comm_pkg::*;

  typedef enum logic [1:0] {HDR, PAYLOAD, CHECKSUM, SKIP} parse_state_e;

  parse_state_e state;
  logic [2:0]   hdr_idx;
  pkt_len_t     remain;
  logic         skip_len;
  byte_t        ver_r;
  logic         in_xfer;
  logic         hdr_xfer;
  logic         hdr_end;
  logic         ver_bad;
  logic         type_bad;
  logic         len_bad;

  assign in_ready = (state == HDR) ? 1'b1 : pl_ready;
  assign pl_valid = in_valid && (state != HDR);
  assign in_xfer  = in_valid && in_ready;
  assign hdr_xfer = in_xfer && (state == HDR);
  assign hdr_end  = (hdr_idx == 3'(`PKT_HEADER_LEN - 1));
  assign busy     = (state != HDR) || (hdr_idx != 3'd0);

  // Fields are complete by the reserved byte
  assign ver_bad  = (ver_r != 8'(`PKT_COMM_VERSION));
  assign type_bad = (hdr_type < 8'(`PKT_TYPE_MIN)) || (hdr_type > 8'(`PKT_TYPE_MAX));
  assign len_bad  = (hdr_len == '0) || (hdr_len > 24'(`PKT_MAX_LEN));

  always_comb begin
    pl_out.data    = in_data;
    pl_out.last    = in_last;
    pl_out.kind    = KIND_SKIP;
    pl_out.len_err = 1'b0;
    case (state)
      PAYLOAD: begin
        // Any tlast before the checksum is early
        pl_out.kind    = KIND_PAYLOAD;
        pl_out.len_err = in_last;
      end
      CHECKSUM: pl_out.kind = in_last ? KIND_CHECKSUM : KIND_SKIP;
      SKIP:     pl_out.len_err = skip_len && in_last;
      default:  pl_out.kind = KIND_SKIP;
    endcase
  end

  assign err_version = hdr_xfer && hdr_end && !in_last && ver_bad;
  assign err_type    = hdr_xfer && hdr_end && !in_last && type_bad;
  assign err_len     = (hdr_xfer && (in_last || (hdr_end && len_bad)))
                    || (in_xfer && (state != HDR) && pl_out.len_err);

  always_ff @(posedge CLK) begin
    if (hdr_xfer) begin
      case (hdr_idx)
        3'd0: ver_r          <= in_data;
        3'd1: hdr_type       <= in_data;
        3'd2: hdr_id[7:0]    <= in_data;
        3'd3: hdr_id[15:8]   <= in_data;
        3'd4: hdr_len[7:0]   <= in_data;
        3'd5: hdr_len[15:8]  <= in_data;
        3'd6: hdr_len[23:16] <= in_data;
        default: ;
      endcase
    end
  end

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      state    <= HDR;
      hdr_idx  <= '0;
      remain   <= '0;
      skip_len <= 1'b0;
    end else if (in_xfer) begin
      case (state)
        HDR: begin
          if (in_last) begin
            hdr_idx <= '0;
          end else if (hdr_end) begin
            hdr_idx <= '0;
            if (ver_bad || type_bad || len_bad) begin
              state    <= SKIP;
              skip_len <= 1'b0;
            end else begin
              state  <= PAYLOAD;
              remain <= hdr_len;
            end
          end else begin
            hdr_idx <= hdr_idx + 3'd1;
          end
        end
        PAYLOAD: begin
          remain <= remain - 1'b1;
          if (in_last) state <= HDR;
          else if (remain == 24'd1) state <= CHECKSUM;
        end
        CHECKSUM: begin
          if (in_last) begin
            state <= HDR;
          end else begin
            // Late tlast, drain and flag on the last byte
            state    <= SKIP;
            skip_len <= 1'b1;
          end
        end
        default: if (in_last) state <= HDR;
      endcase
    end
  end

endmodule

//--- hdl/axis_in_fifo.sv
/*
 * Input byte FIFO, tlast stored alongside each byte.
 * DEPTH must be a power of two. Output is a combinational read of the head entry.
 */
`include "pkt_comm_consts.svh"

module axis_in_fifo #(
  parameter int DEPTH = `IN_FIFO_DEPTH
) (
  input  logic                 CLK,
  input  logic                 RSTN,
  input  pkt_comm_pkg::byte_t  s_axis_tdata,
  input  logic                 s_axis_tvalid,
  output logic                 s_axis_tready,
  input  logic                 s_axis_tlast,
  output pkt_comm_pkg::byte_t  out_data,
  output logic                 out_last,
  output logic                 out_valid,
  input  logic                 out_ready
);
  import pkt_comm_pkg::*;

  localparam int AW = $clog2(DEPTH);

  logic [8:0]  mem [DEPTH];
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        full;
  logic        empty;

  // Same address, different lap bit
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign empty = (wr_ptr == rd_ptr);

  assign s_axis_tready = ~full;
  assign out_valid     = ~empty;
  assign {out_last, out_data} = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge CLK) begin
    if (s_axis_tvalid && s_axis_tready) begin
      mem[wr_ptr[AW-1:0]] <= {s_axis_tlast, s_axis_tdata};
    end
  end

  always_ff @(posedge CLK or negedge RSTN) begin
    if (!RSTN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (s_axis_tvalid && s_axis_tready) wr_ptr <= wr_ptr + 1'b1;
      if (out_valid && out_ready) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Occupancy from the pointers must leave room for every accepted write
  a_no_write_full: assert property (@(posedge CLK) disable iff (!RSTN)
    (s_axis_tvalid && s_axis_tready) |-> ((AW+1)'(wr_ptr - rd_ptr) < DEPTH))
    else $error("write accepted while FIFO full");

endmodule

//--- hdl/pkt_comm_pkg.sv
/*
 * Shared types for the packet front end.
 * len_err in pl_byte_s is meaningful only on a byte with last set.
 */
package pkt_comm_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] word_t;
  typedef logic [15:0] pkt_id_t;
  typedef logic [7:0]  pkt_type_t;
  typedef logic [23:0] pkt_len_t;
  typedef logic [15:0] sum_t;

  // Bit 0 checksum, 1 length, 2 type, 3 version
  typedef logic [3:0]  err_bits_t;

  typedef enum logic [1:0] {
    KIND_PAYLOAD  = 2'd0,
    KIND_CHECKSUM = 2'd1,
    KIND_SKIP     = 2'd2
  } byte_kind_e;

  // One byte after the header, tagged by the parser
  typedef struct packed {
    byte_t      data;
    byte_kind_e kind;
    logic       last;
    logic       len_err;
  } pl_byte_s;

  // Per-packet record for the result builder
  typedef struct packed {
    pkt_type_t pkt_type;
    pkt_id_t   pkt_id;
    pkt_len_t  pkt_len;
    sum_t      sum;
  } summary_s;

endpackage

//--- hdl/pkt_comm_consts.svh
/*
 * Protocol and sizing constants for the packet front end.
 * PKT_MAX_LEN must fit the 24-bit length field; IN_FIFO_DEPTH must be a power of two.
 */
`ifndef PKT_COMM_CONSTS_SVH
`define PKT_COMM_CONSTS_SVH

// Header fields
`define PKT_COMM_VERSION 2
`define PKT_TYPE_MIN 1
`define PKT_TYPE_MAX 4
`define PKT_HEADER_LEN 8

// Payload length limit in bytes
`define PKT_MAX_LEN 1048576

// Input buffer depth in bytes
`define IN_FIFO_DEPTH 2048

// Quiet cycles before idle is raised
`define IDLE_DELAY 64

`endif
